// File: common/mm_macros.svh
/*
 * Matrix-multiply accelerator sizes
 * Element format, accumulator width and tiling of the 4x4 problem
 */
`ifndef MM_MACROS_SVH
`define MM_MACROS_SVH

// Signed Q8.8 elements
`define MM_ELEM_W 16
`define MM_FRAC_W 8

// Full-precision sum of K products
`define MM_ACC_W 32

// Shared dimension K
`define MM_INNER_DIM 4

// 2x2 output tiles over a 4x4 result
`define MM_ROW_GROUPS 2
`define MM_COL_GROUPS 2

// Operand memory depth is 8 words
`define MM_ADDR_W 3

`endif

// File: common/mm_pkg.sv
/*
 * Matrix-multiply shared types
 * Element and accumulator types, memory words, host write strobe,
 * beat tags, tile result and the sequencer state
 */
package mm_pkg;

`include "mm_macros.svh"

    // One Q8.8 element
    typedef logic signed [`MM_ELEM_W-1:0] elem_t;

    // Accumulator, no rounding until end of tile
    typedef logic signed [`MM_ACC_W-1:0] acc_t;

    // Two rows side by side for one k
    // I memory: word g*K+k holds I[2g][k] in lo, I[2g+1][k] in hi
    // W memory uses the same layout for W rows
    typedef struct packed {
        elem_t hi;
        elem_t lo;
    } operand_word_t;

    // Host write port, one-cycle strobe
    typedef struct packed {
        logic                  en;
        logic [`MM_ADDR_W-1:0] addr;
        operand_word_t         data;
    } mem_wr_t;

    // Tag riding alongside operand data
    typedef struct packed {
        logic valid;
        logic first; // k == 0, load accumulators
        logic last;  // k == K-1, close the tile
    } beat_t;

    // cXY is C[2*tile_row+X][2*tile_col+Y]
    typedef struct packed {
        logic  tile_row;
        logic  tile_col;
        elem_t c00;
        elem_t c01;
        elem_t c10;
        elem_t c11;
    } tile_result_t;

    // Run controller states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } seq_state_e;

endpackage

// File: hdl/operand_ram.sv
/*
 * Operand memory
 * 8 words of two elements, host write port and one registered read port
 */
`include "mm_macros.svh"

module operand_ram (
    input  logic                  clk,
    input  mm_pkg::mem_wr_t       wr,      // Host side
    input  logic                  rd_en,
    input  logic [`MM_ADDR_W-1:0] rd_addr,
    output mm_pkg::operand_word_t rd_data  // Valid one cycle after rd_en
);

    localparam int DEPTH = 1 << `MM_ADDR_W;

    // Contents kept across runs
    mm_pkg::operand_word_t mem [0:DEPTH-1];

    // Write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read port, old word on same-address collision
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: mm_core/tile_sequencer.sv
/*
 * Tile sequencer
 * Walks the four 2x2 output tiles row group first, issues one operand read
 * per cycle to both memories, tags each beat and counts finished tiles
 */
`include "mm_macros.svh"

module tile_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,        // Level, taken in IDLE
    input  logic                  result_valid, // One pulse per finished tile
    output logic                  rd_en,
    output logic [`MM_ADDR_W-1:0] in_rd_addr,
    output logic [`MM_ADDR_W-1:0] wt_rd_addr,
    output mm_pkg::beat_t         beat,         // Aligned with read data
    output logic [1:0]            tile_pos,     // {row, col}, aligned with beat
    output logic                  busy,
    output logic                  done
);

    localparam int K_W      = $clog2(`MM_INNER_DIM);
    localparam int K_LAST   = `MM_INNER_DIM - 1;
    localparam int COL_LAST = `MM_COL_GROUPS - 1;
    localparam int ROW_LAST = `MM_ROW_GROUPS - 1;
    localparam int TILES    = `MM_ROW_GROUPS * `MM_COL_GROUPS;
    localparam int CNT_W    = $clog2(TILES);

    mm_pkg::seq_state_e state;

    logic [K_W-1:0]   k;       // Inner index
    logic             col;     // Tile column, inner loop
    logic             row;     // Tile row, outer loop
    logic             issuing; // Reads still to go
    logic [CNT_W-1:0] res_cnt; // Tiles finished this run

    logic             issue_now;
    mm_pkg::beat_t    iss_beat; // Tag at the read address stage
    logic [1:0]       iss_pos;

    assign issue_now = (state == mm_pkg::RUN) && issuing;

    // Control FSM and loop counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= mm_pkg::IDLE;
            issuing <= 1'b0;
            k       <= '0;
            col     <= 1'b0;
            row     <= 1'b0;
            res_cnt <= '0;
        end else begin
            case (state)
                mm_pkg::IDLE: begin
                    if (start) begin
                        state   <= mm_pkg::RUN;
                        issuing <= 1'b1;
                        k       <= '0;
                        col     <= 1'b0;
                        row     <= 1'b0;
                        res_cnt <= '0;
                    end
                end
                mm_pkg::RUN: begin
                    if (issuing) begin
                        if (k == K_W'(K_LAST)) begin
                            k <= '0;
                            if (col == 1'(COL_LAST)) begin
                                col <= 1'b0;
                                if (row == 1'(ROW_LAST)) begin
                                    row     <= 1'b0;
                                    issuing <= 1'b0; // All 16 beats out
                                end else begin
                                    row <= row + 1'b1;
                                end
                            end else begin
                                col <= col + 1'b1;
                            end
                        end else begin
                            k <= k + 1'b1;
                        end
                    end
                    // Fourth tile back ends the run
                    if (result_valid) begin
                        if (res_cnt == CNT_W'(TILES - 1)) begin
                            state <= mm_pkg::DONE;
                        end
                        res_cnt <= res_cnt + 1'b1;
                    end
                end
                mm_pkg::DONE: begin
                    if (!start) begin
                        state <= mm_pkg::IDLE; // Wait for start to drop
                    end
                end
                default: state <= mm_pkg::IDLE;
            endcase
        end
    end

    // Read addresses, I by tile row and W by tile column
    always_ff @(posedge clk) begin
        in_rd_addr <= `MM_ADDR_W'(row * `MM_INNER_DIM + k);
        wt_rd_addr <= `MM_ADDR_W'(col * `MM_INNER_DIM + k);
        iss_pos    <= {row, col};
        tile_pos   <= iss_pos; // One stage behind, matches read latency
    end

    // Beat flags, issue stage then alignment stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iss_beat <= '0;
            beat     <= '0;
        end else begin
            iss_beat.valid <= issue_now;
            iss_beat.first <= issue_now && (k == '0);
            iss_beat.last  <= issue_now && (k == K_W'(K_LAST));
            beat           <= iss_beat;
        end
    end

    assign rd_en = iss_beat.valid;  // Shared by both memories
    assign busy  = (state == mm_pkg::RUN);
    assign done  = (state == mm_pkg::DONE);

endmodule

// File: mm_core/mac_tile.sv
/*
 * 2x2 multiply-accumulate tile
 * Outer product of an I pair and a W pair per beat, summed over K,
 * then shifted to Q8.8, saturated and registered as one tile result
 */
`include "mm_macros.svh"

module mac_tile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mm_pkg::beat_t         beat,
    input  logic [1:0]            tile_pos, // {row, col}
    input  mm_pkg::operand_word_t i_word,   // I rows 2r and 2r+1
    input  mm_pkg::operand_word_t w_word,   // W rows 2c and 2c+1
    output logic                  result_valid,
    output mm_pkg::tile_result_t  result
);

    localparam mm_pkg::acc_t SAT_MAX = (2 ** (`MM_ELEM_W - 1)) - 1;
    localparam mm_pkg::acc_t SAT_MIN = -(2 ** (`MM_ELEM_W - 1));

    mm_pkg::acc_t prod [0:3]; // Index is 2*X+Y for cXY
    mm_pkg::acc_t acc  [0:3];
    logic         fin;        // Last beat just landed
    logic [1:0]   pos_q;      // Position of the tile being closed

    // Back to Q8.8, floor on negatives, clip to 16 bits
    function automatic mm_pkg::elem_t rescale(input mm_pkg::acc_t sum);
        mm_pkg::acc_t shifted;
        shifted = sum >>> `MM_FRAC_W;
        if (shifted > SAT_MAX) begin
            shifted = SAT_MAX;
        end else if (shifted < SAT_MIN) begin
            shifted = SAT_MIN;
        end
        return mm_pkg::elem_t'(shifted);
    endfunction

    // Signed 16x16 products, sign extended to 32
    assign prod[0] = i_word.lo * w_word.lo;
    assign prod[1] = i_word.lo * w_word.hi;
    assign prod[2] = i_word.hi * w_word.lo;
    assign prod[3] = i_word.hi * w_word.hi;

    // Accumulators, first beat loads and the rest add
    always_ff @(posedge clk) begin
        if (beat.valid) begin
            for (int n = 0; n < 4; n++) begin
                acc[n] <= beat.first ? prod[n] : acc[n] + prod[n];
            end
            if (beat.last) begin
                pos_q <= tile_pos;
            end
        end
    end

    // Result register, one cycle after the last beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fin          <= 1'b0;
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            fin          <= beat.valid && beat.last;
            result_valid <= fin; // Single-cycle pulse
            if (fin) begin
                result.tile_row <= pos_q[1];
                result.tile_col <= pos_q[0];
                result.c00      <= rescale(acc[0]);
                result.c01      <= rescale(acc[1]);
                result.c10      <= rescale(acc[2]);
                result.c11      <= rescale(acc[3]);
            end
        end
    end

endmodule

// File: hdl/mm_top.sv
/*
 * Matrix-multiply accelerator top
 * Two operand memories, the tile sequencer and the 2x2 MAC tile
 */
`include "mm_macros.svh"

module mm_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  mm_pkg::mem_wr_t      in_wr,        // Input matrix I load
    input  mm_pkg::mem_wr_t      wt_wr,        // Weight matrix W load
    output logic                 busy,
    output logic                 done,
    output logic                 result_valid,
    output mm_pkg::tile_result_t result
);

    logic                  rd_en;
    logic [`MM_ADDR_W-1:0] in_rd_addr;
    logic [`MM_ADDR_W-1:0] wt_rd_addr;
    mm_pkg::operand_word_t in_data;
    mm_pkg::operand_word_t wt_data;
    mm_pkg::beat_t         beat;
    logic [1:0]            tile_pos;

    // I memory
    operand_ram in_ram_i (
        .clk     (clk),
        .wr      (in_wr),
        .rd_en   (rd_en),
        .rd_addr (in_rd_addr),
        .rd_data (in_data)
    );

    // W memory, rows stored like I
    operand_ram wt_ram_i (
        .clk     (clk),
        .wr      (wt_wr),
        .rd_en   (rd_en),
        .rd_addr (wt_rd_addr),
        .rd_data (wt_data)
    );

    // Run control and address generation
    tile_sequencer seq_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .result_valid (result_valid), // Tile completion count
        .rd_en        (rd_en),
        .in_rd_addr   (in_rd_addr),
        .wt_rd_addr   (wt_rd_addr),
        .beat         (beat),
        .tile_pos     (tile_pos),
        .busy         (busy),
        .done         (done)
    );

    // Datapath
    mac_tile mac_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat         (beat),
        .tile_pos     (tile_pos),
        .i_word       (in_data),
        .w_word       (wt_data),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// File: verif/mm_ref_model.svh
/*
 * Reference model for the matrix-multiply testbench
 * Expected Q8.8 tiles from the testbench copies of I and W
 */
`ifndef MM_REF_MODEL_SVH
`define MM_REF_MODEL_SVH

// C[r][c] is the sum over k of I[r][k] * W[c][k]
function automatic mm_pkg::elem_t ref_elem(input int r, input int c);
    int sum;
    sum = 0;
    for (int k = 0; k < `MM_INNER_DIM; k++) begin
        sum += int'(i_mat[r][k]) * int'(w_mat[c][k]); // 32-bit products
    end
    sum = sum >>> `MM_FRAC_W; // Floor, also for negatives
    if (sum > 32767) begin
        sum = 32767;
    end else if (sum < -32768) begin
        sum = -32768;
    end
    return mm_pkg::elem_t'(sum);
endfunction

// One 2x2 output tile with its position
function automatic mm_pkg::tile_result_t expected_tile(input int tr, input int tc);
    mm_pkg::tile_result_t t;
    t.tile_row = tr[0];
    t.tile_col = tc[0];
    t.c00      = ref_elem(2 * tr, 2 * tc);
    t.c01      = ref_elem(2 * tr, 2 * tc + 1);
    t.c10      = ref_elem(2 * tr + 1, 2 * tc);
    t.c11      = ref_elem(2 * tr + 1, 2 * tc + 1);
    return t;
endfunction

`endif

// File: verif/mm_tb.sv
/*
 * Testbench for the matrix-multiply accelerator
 * Loads I and W, runs the four tiles and checks them against a model
 */
`include "mm_macros.svh"

module mm_tb;

    localparam int WAIT_LIMIT = 100; // Cycles allowed per wait

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 start;
    mm_pkg::mem_wr_t      in_wr;
    mm_pkg::mem_wr_t      wt_wr;
    logic                 busy;
    logic                 done;
    logic                 result_valid;
    mm_pkg::tile_result_t result;

    mm_pkg::elem_t i_mat [0:3][0:3]; // Testbench copy of I
    mm_pkg::elem_t w_mat [0:3][0:3]; // W rows, C = I * W^T
    logic [31:0]   lfsr;
    int            errors;
    int            errors_before;
    int            pass_cnt;
    int            fail_cnt;

    `include "mm_ref_model.svh"

    mm_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .in_wr        (in_wr),
        .wt_wr        (wt_wr),
        .busy         (busy),
        .done         (done),
        .result_valid (result_valid),
        .result       (result)
    );

    always #20 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Signed element of nbits, sign extended to Q8.8
    function automatic mm_pkg::elem_t rand_elem(input int nbits);
        logic [31:0] v;
        v = rand_bits(nbits) << (32 - nbits);
        return mm_pkg::elem_t'($signed(v) >>> (32 - nbits));
    endfunction

    task automatic expect_eq(input string what, input logic signed [31:0] got,
                             input logic signed [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // Word g*K+k holds row 2g in lo and row 2g+1 in hi
    task automatic load_mem(input bit to_wt);
        mm_pkg::mem_wr_t w;
        for (int g = 0; g < 2; g++) begin
            for (int k = 0; k < 4; k++) begin
                w.en      = 1'b1;
                w.addr    = 3'(g * 4 + k);
                w.data.lo = to_wt ? w_mat[2 * g][k] : i_mat[2 * g][k];
                w.data.hi = to_wt ? w_mat[2 * g + 1][k] : i_mat[2 * g + 1][k];
                @(posedge clk);
                if (to_wt) begin
                    wt_wr <= w;
                end else begin
                    in_wr <= w;
                end
            end
        end
        @(posedge clk);
        in_wr.en <= 1'b0;
        wt_wr.en <= 1'b0;
    endtask

    task automatic match_tile(input int n);
        mm_pkg::tile_result_t exp;
        exp = expected_tile(n / 2, n % 2);
        expect_eq($sformatf("tile %0d row", n), result.tile_row, n / 2);
        expect_eq($sformatf("tile %0d col", n), result.tile_col, n % 2);
        expect_eq($sformatf("tile %0d c00", n), result.c00, exp.c00);
        expect_eq($sformatf("tile %0d c01", n), result.c01, exp.c01);
        expect_eq($sformatf("tile %0d c10", n), result.c10, exp.c10);
        expect_eq($sformatf("tile %0d c11", n), result.c11, exp.c11);
    endtask

    // Raise start, collect tiles until done, start left high
    task automatic run_tiles();
        int cycles;
        int n_res;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk); // Start seen in IDLE here
        cycles = 0;
        n_res  = 0;
        @(negedge clk);
        while (!done && cycles < WAIT_LIMIT) begin
            expect_eq("busy during run", busy, 1);
            if (result_valid) begin
                if (n_res < 4) begin
                    match_tile(n_res);
                end
                n_res++;
            end
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: done did not rise within %0d cycles", WAIT_LIMIT);
            errors++;
        end
        expect_eq("busy at done", busy, 0);
        expect_eq("tiles per run", n_res, 4);
    endtask

    // Drop start and wait for the return to IDLE
    task automatic release_start();
        int cycles;
        @(posedge clk);
        start  <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (done && cycles < WAIT_LIMIT) begin
            expect_eq("result_valid after done", result_valid, 0);
            @(negedge clk);
            cycles++;
        end
        if (done) begin
            $display("Timeout: done stayed high after start was dropped");
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_before) begin
            pass_cnt++;
            $display("Test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("Test %s: failed with %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        in_wr = '0;
        wt_wr = '0;
        lfsr  = 32'h3100;
        errors = 0;
        errors_before = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        expect_eq("busy after reset", busy, 0);
        expect_eq("done after reset", done, 0);
        expect_eq("result_valid after reset", result_valid, 0);
        expect_eq("result cleared", result == '0, 1);
        end_test("reset state");

        // Small magnitudes, roughly +-2.0
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                i_mat[r][k] = rand_elem(10);
                w_mat[r][k] = rand_elem(10);
            end
        end
        load_mem(1'b0);
        load_mem(1'b1);
        run_tiles();
        release_start();
        end_test("random run");

        // Two +-127.0 terms per sum overflow Q8.8, W row 3 keeps only fractions
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                if (k < 2) begin
                    i_mat[r][k] = (r % 2 == 0) ? 16'sh7F00 : -16'sh7F00;
                    w_mat[r][k] = (r == 3) ? 16'sh0000 :
                                  (r == 1) ? -16'sh7F00 : 16'sh7F00;
                end else begin
                    i_mat[r][k] = rand_elem(9);
                    w_mat[r][k] = rand_elem(9);
                end
            end
        end
        i_mat[2][2] = -16'sh0080; // -0.5 times 1/256 floors to -1
        w_mat[3][2] = 16'sh0001;
        w_mat[3][3] = 16'sh0000;
        load_mem(1'b0);
        load_mem(1'b1);
        run_tiles();
        expect_eq("clip high", result.c00, 32767); // Tile (1,1) still held
        expect_eq("clip low", result.c10, -32768);
        expect_eq("floor of negative fraction", result.c01, -1);
        release_start();
        end_test("saturation");

        run_tiles();
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            expect_eq("done held with start high", done, 1);
            expect_eq("no result while done", result_valid, 0);
        end
        release_start();
        repeat (4) begin
            @(negedge clk);
            expect_eq("idle busy", busy, 0);
            expect_eq("idle done", done, 0);
            expect_eq("idle result_valid", result_valid, 0);
        end
        end_test("handshake");

        // New W only, I from the previous load
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                w_mat[r][k] = rand_elem(10);
            end
        end
        load_mem(1'b1);
        run_tiles();
        release_start();
        end_test("rerun with W reload");

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: mm_top.f
+incdir+common
+incdir+verif
common/mm_pkg.sv
hdl/operand_ram.sv
mm_core/tile_sequencer.sv
mm_core/mac_tile.sv
hdl/mm_top.sv
verif/mm_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the matrix-multiply testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module mm_tb -f mm_top.f -o mm_sim

./obj_dir/mm_sim | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"
